/* verilog/mips_isa_pkg.sv */
package mips_isa_pkg;

    localparam int INST_W = 32;

    // field positions inside an instruction word
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int SA_LSB     = 6;
    localparam int FUNCT_LSB  = 0;
    localparam int SA_W       = 5;
    localparam int IMM_W      = 16;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // function field of SPECIAL, integer subset only
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

endpackage

/* verilog/core_pkg.sv */
package core_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 1 << REG_AW;

    // immediate as carried in a micro-op, extended in execute
    localparam int IMM_STORE_W = 16;

    typedef enum logic [3:0] {
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        EXT_ZERO,
        EXT_SIGN,
        EXT_UPPER   // lui placement
    } imm_ext_e;

    typedef struct packed {
        alu_op_e                  alu_op;
        logic [REG_AW-1:0]        rs_addr;
        logic [REG_AW-1:0]        rt_addr;      // operand b unless use_imm
        logic                     use_imm;
        logic [IMM_STORE_W-1:0]   imm;
        imm_ext_e                 imm_ext;
        logic [REG_AW-1:0]        wd;
        logic                     shift_by_imm; // shamt from imm, not rs
    } uop_t;

endpackage

/* verilog/uop_if.sv */
`timescale 1ns/1ps

interface uop_if import core_pkg::*; ();

    logic valid;
    logic ready;
    uop_t uop;

    // upstream side
    modport producer (
        output valid,
        output uop,
        input  ready
    );

    modport consumer (
        input  valid,
        input  uop,
        output ready
    );

endinterface

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import mips_isa_pkg::*, core_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              inst_req_i,
    input  logic [INST_W-1:0] inst_i,
    output logic              inst_ack_o,
    uop_if.producer           uop_o
);

    typedef enum logic [1:0] {
        IDLE,
        ACKED,
        WAIT_SLOT
    } state_e;

    state_e  state_q, state_d;
    logic    valid_q;
    uop_t    uop_q;
    uop_t    dec_uop;
    logic    dec_ok;
    logic    accept;
    opcode_e opcode;
    funct_e  funct;

    function automatic alu_op_e funct_alu(funct_e f);
        case (f)
            FN_SLL, FN_SLLV: return ALU_SLL;
            FN_SRL, FN_SRLV: return ALU_SRL;
            FN_SRA, FN_SRAV: return ALU_SRA;
            FN_ADD, FN_ADDU: return ALU_ADD;  // no overflow trap
            FN_SUB, FN_SUBU: return ALU_SUB;
            FN_AND:          return ALU_AND;
            FN_XOR:          return ALU_XOR;
            FN_NOR:          return ALU_NOR;
            FN_SLT:          return ALU_SLT;
            FN_SLTU:         return ALU_SLTU;
            default:         return ALU_OR;
        endcase
    endfunction

    assign opcode = opcode_e'(inst_i[OPCODE_LSB +: $bits(opcode_e)]);
    assign funct  = funct_e'(inst_i[FUNCT_LSB +: $bits(funct_e)]);

    always_comb begin
        dec_uop.alu_op       = ALU_OR;
        dec_uop.rs_addr      = inst_i[RS_LSB +: REG_AW];
        dec_uop.rt_addr      = inst_i[RT_LSB +: REG_AW];
        dec_uop.use_imm      = 1'b1;
        dec_uop.imm          = inst_i[IMM_W-1:0];
        dec_uop.imm_ext      = EXT_ZERO;
        dec_uop.wd           = inst_i[RT_LSB +: REG_AW];  // i-type writes rt
        dec_uop.shift_by_imm = 1'b0;
        dec_ok               = 1'b1;
        case (opcode)
            OP_SPECIAL: begin
                dec_uop.use_imm = 1'b0;
                dec_uop.wd      = inst_i[RD_LSB +: REG_AW];
                dec_uop.alu_op  = funct_alu(funct);
                case (funct)
                    FN_SLL, FN_SRL, FN_SRA: begin
                        dec_ok               = (inst_i[RS_LSB +: REG_AW] == '0);
                        dec_uop.shift_by_imm = 1'b1;
                        dec_uop.imm          = IMM_STORE_W'(inst_i[SA_LSB +: SA_W]);
                    end
                    FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                    FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU:
                        dec_ok = (inst_i[SA_LSB +: SA_W] == '0);
                    default: dec_ok = 1'b0;
                endcase
            end
            OP_ORI:  dec_uop.alu_op = ALU_OR;
            OP_ANDI: dec_uop.alu_op = ALU_AND;
            OP_XORI: dec_uop.alu_op = ALU_XOR;
            OP_LUI: begin
                dec_uop.rs_addr = '0;  // or with r0
                dec_uop.imm_ext = EXT_UPPER;
            end
            OP_ADDI, OP_ADDIU: begin
                dec_uop.alu_op  = ALU_ADD;
                dec_uop.imm_ext = EXT_SIGN;
            end
            OP_SLTI: begin
                dec_uop.alu_op  = ALU_SLT;
                dec_uop.imm_ext = EXT_SIGN;
            end
            OP_SLTIU: begin
                dec_uop.alu_op  = ALU_SLTU;
                dec_uop.imm_ext = EXT_SIGN;  // sign extended, compared unsigned
            end
            default: dec_ok = 1'b0;
        endcase
    end

    // take a new request only when the output slot is free this edge
    assign accept = inst_req_i &&
                    ((state_q == IDLE) || ((state_q == WAIT_SLOT) && uop_o.ready));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (inst_req_i) state_d = ACKED;
            ACKED: begin
                if (!inst_req_i) begin
                    state_d = (valid_q && !uop_o.ready) ? WAIT_SLOT : IDLE;
                end
            end
            WAIT_SLOT: if (uop_o.ready) state_d = inst_req_i ? ACKED : IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= IDLE;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                valid_q <= dec_ok;  // undefined encodings vanish here
            end else if (valid_q && uop_o.ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) uop_q <= dec_uop;
    end

    assign inst_ack_o  = (state_q == ACKED);
    assign uop_o.valid = valid_q;
    assign uop_o.uop   = uop_q;

    a_uop_held: assert property (@(posedge clk_i) disable iff (reset_i)
        uop_o.valid && !uop_o.ready |=> uop_o.valid && $stable(uop_o.uop));

endmodule

/* verilog/uop_queue.sv */
`timescale 1ns/1ps

module uop_queue import core_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic     clk_i,
    input  logic     reset_i,
    uop_if.consumer  in_o,
    uop_if.producer  out_o
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    uop_t             mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign in_o.ready  = (count != QUEUE_DEPTH);
    assign out_o.valid = (count != '0);
    assign out_o.uop   = mem[rd_ptr];  // no bypass from the write side

    assign push = in_o.valid && in_o.ready;
    assign pop  = out_o.valid && out_o.ready;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is 2^n
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) mem[wr_ptr] <= in_o.uop;
    end

    // an unread head is never overwritten and reads never pass the writes
    a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
        push && (count != '0) |-> wr_ptr != rd_ptr);

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
        pop && (count != QUEUE_DEPTH) |-> rd_ptr != wr_ptr);

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic [REG_AW-1:0] rd_a_addr_i,
    input  logic [REG_AW-1:0] rd_b_addr_i,
    output logic [XLEN-1:0]   rd_a_data_o,
    output logic [XLEN-1:0]   rd_b_data_o,
    input  logic              we_i,
    input  logic [REG_AW-1:0] wr_addr_i,
    input  logic [XLEN-1:0]   wr_data_i
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // r0 hardwired
    assign rd_a_data_o = (rd_a_addr_i == '0) ? '0 : regs[rd_a_addr_i];
    assign rd_b_data_o = (rd_b_addr_i == '0) ? '0 : regs[rd_b_addr_i];

endmodule

/* verilog/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec import core_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    uop_if.consumer           uop_i,
    output logic              wb_valid_o,
    input  logic              wb_ready_i,
    output logic [REG_AW-1:0] wb_addr_o,
    output logic [XLEN-1:0]   wb_data_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    uop_t               uop;
    logic               take;
    logic [XLEN-1:0]    rs_data;
    logic [XLEN-1:0]    rt_data;
    logic [XLEN-1:0]    imm_val;
    logic [XLEN-1:0]    op_b;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    result;

    assign uop         = uop_i.uop;
    assign uop_i.ready = !wb_valid_o || wb_ready_i;
    assign take        = uop_i.valid && uop_i.ready;

    reg_file u_reg_file (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .rd_a_addr_i (uop.rs_addr),
        .rd_b_addr_i (uop.rt_addr),
        .rd_a_data_o (rs_data),
        .rd_b_data_o (rt_data),
        .we_i        (take),
        .wr_addr_i   (uop.wd),
        .wr_data_i   (result)
    );

    always_comb begin
        case (uop.imm_ext)
            EXT_SIGN:  imm_val = {{(XLEN - IMM_STORE_W){uop.imm[IMM_STORE_W-1]}}, uop.imm};
            EXT_UPPER: imm_val = {uop.imm, {(XLEN - IMM_STORE_W){1'b0}}};
            default:   imm_val = {{(XLEN - IMM_STORE_W){1'b0}}, uop.imm};
        endcase
    end

    assign op_b  = uop.use_imm ? imm_val : rt_data;
    assign shamt = uop.shift_by_imm ? uop.imm[SHAMT_W-1:0] : rs_data[SHAMT_W-1:0];

    // shifts always act on rt
    always_comb begin
        case (uop.alu_op)
            ALU_OR:   result = rs_data | op_b;
            ALU_AND:  result = rs_data & op_b;
            ALU_XOR:  result = rs_data ^ op_b;
            ALU_NOR:  result = ~(rs_data | op_b);
            ALU_SLL:  result = rt_data << shamt;
            ALU_SRL:  result = rt_data >> shamt;
            ALU_SRA:  result = $signed(rt_data) >>> shamt;
            ALU_ADD:  result = rs_data + op_b;
            ALU_SUB:  result = rs_data - op_b;
            ALU_SLT:  result = XLEN'($signed(rs_data) < $signed(op_b));
            ALU_SLTU: result = XLEN'(rs_data < op_b);
            default:  result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
        end else if (take) begin
            wb_valid_o <= 1'b1;
        end else if (wb_ready_i) begin
            wb_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            wb_addr_o <= uop.wd;
            wb_data_o <= result;
        end
    end

    a_wb_held: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_addr_o) && $stable(wb_data_o));

endmodule

/* verilog/decode_exec_core.sv */
`timescale 1ns/1ps

module decode_exec_core import mips_isa_pkg::*, core_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              inst_req_i,
    input  logic [INST_W-1:0] inst_i,
    output logic              inst_ack_o,
    output logic              wb_valid_o,
    input  logic              wb_ready_i,
    output logic [REG_AW-1:0] wb_addr_o,
    output logic [XLEN-1:0]   wb_data_o
);

    uop_if dec_q ();
    uop_if q_ex ();

    inst_decoder u_inst_decoder (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .inst_req_i (inst_req_i),
        .inst_i     (inst_i),
        .inst_ack_o (inst_ack_o),
        .uop_o      (dec_q.producer)
    );

    uop_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_uop_queue (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .in_o    (dec_q.consumer),
        .out_o   (q_ex.producer)
    );

    alu_exec u_alu_exec (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .uop_i      (q_ex.consumer),
        .wb_valid_o (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // released just after the last reset edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_o = 1'b0;
    end

endmodule

/* dv/decode_exec_core_tb.sv */
`timescale 1ns/1ps

module decode_exec_core_tb import mips_isa_pkg::*; ();

    localparam int DRIVE_DLY   = 1;
    localparam int STEP_CYCLES = 40;
    localparam int BASE_CYCLES = 200;

    logic        clk_i;
    logic        reset_i;
    logic        inst_req_i;
    logic [31:0] inst_i;
    logic        inst_ack_o;
    logic        wb_valid_o;
    logic        wb_ready_i;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o;

    logic [31:0] model_regs [32];
    logic [4:0]  exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    string       exp_name_q [$];
    string       test_name  = "reset";
    logic        bp_mode    = 1'b0;
    int          sent_cnt   = 0;
    int          cycle_cnt  = 0;
    int          data_errs  = 0;
    int          proto_errs = 0;
    int          other_errs = 0;
    logic        prev_req   = 1'b0;
    logic        prev_ack   = 1'b0;
    logic [4:0]  pop_addr;
    logic [31:0] pop_data;
    string       pop_name;

    logic [5:0] kept_fn [16] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
                                 FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
                                 FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    logic [5:0] kept_op [8]  = '{OP_ORI, OP_ANDI, OP_XORI, OP_LUI,
                                 OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(5)) u_clock_gen (
        .clk_o   (clk_i),
        .reset_o (reset_i)
    );

    decode_exec_core #(.QUEUE_DEPTH(4)) DUT (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .inst_req_i (inst_req_i),
        .inst_i     (inst_i),
        .inst_ack_o (inst_ack_o),
        .wb_valid_o (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

    // expected register write of one instruction, 0 when it is discarded
    function automatic logic ref_exec(input logic [31:0] inst, input logic [31:0] regs [32],
                                      output logic [4:0] wd, output logic [31:0] val);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [4:0]  sa;
        logic        ok;
        a    = regs[inst[25:21]];
        b    = regs[inst[20:16]];
        sa   = inst[10:6];
        sext = {{16{inst[15]}}, inst[15:0]};
        wd   = inst[20:16];
        val  = '0;
        ok   = 1'b1;
        case (inst[31:26])
            OP_SPECIAL: begin
                wd = inst[15:11];
                ok = (inst[5:0] inside {FN_SLL, FN_SRL, FN_SRA}) ? (inst[25:21] == 0) : (sa == 0);
                case (inst[5:0])
                    FN_SLL:          val = b << sa;
                    FN_SRL:          val = b >> sa;
                    FN_SRA:          val = $signed(b) >>> sa;
                    FN_SLLV:         val = b << a[4:0];
                    FN_SRLV:         val = b >> a[4:0];
                    FN_SRAV:         val = $signed(b) >>> a[4:0];
                    FN_ADD, FN_ADDU: val = a + b;
                    FN_SUB, FN_SUBU: val = a - b;
                    FN_AND:          val = a & b;
                    FN_OR:           val = a | b;
                    FN_XOR:          val = a ^ b;
                    FN_NOR:          val = ~(a | b);
                    FN_SLT:          val = {31'b0, $signed(a) < $signed(b)};
                    FN_SLTU:         val = {31'b0, a < b};
                    default:         ok = 1'b0;
                endcase
            end
            OP_ORI:            val = a | {16'b0, inst[15:0]};
            OP_ANDI:           val = a & {16'b0, inst[15:0]};
            OP_XORI:           val = a ^ {16'b0, inst[15:0]};
            OP_LUI:            val = {inst[15:0], 16'b0};
            OP_ADDI, OP_ADDIU: val = a + sext;
            OP_SLTI:           val = {31'b0, $signed(a) < $signed(sext)};
            OP_SLTIU:          val = {31'b0, a < sext};  // sign extended, unsigned compare
            default:           ok = 1'b0;
        endcase
        return ok;
    endfunction

    function automatic logic [31:0] r_type(logic [5:0] fn, int rs, int rt, int rd, int sa);
        return {6'b0, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic logic [31:0] i_type(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // r1..r7 hold boundary and shift values
    function automatic int rnd_reg();
        return $urandom_range(31, 8);
    endfunction

    function automatic logic [31:0] random_inst();
        int k;
        k = $urandom_range(0, 24);
        if (k < 3)
            return r_type(kept_fn[k], 0, $urandom_range(0, 31), $urandom_range(0, 31),
                          $urandom_range(0, 31));
        if (k < 16)
            return r_type(kept_fn[k], $urandom_range(0, 31), $urandom_range(0, 31),
                          $urandom_range(0, 31), 0);
        if (k < 24)
            return i_type(kept_op[k - 16], $urandom_range(0, 31), $urandom_range(0, 31),
                          16'($urandom));
        return i_type(6'b100011, 1, $urandom_range(0, 31), 16'h0);  // lw
    endfunction

    task automatic send_inst(input logic [31:0] inst);
        logic [4:0]  wd;
        logic [31:0] val;
        if (ref_exec(inst, model_regs, wd, val)) begin
            exp_addr_q.push_back(wd);
            exp_data_q.push_back(val);
            exp_name_q.push_back(test_name);
            if (wd != 0) model_regs[wd] = val;
        end
        sent_cnt++;
        @(posedge clk_i);
        #DRIVE_DLY;
        inst_i     = inst;
        inst_req_i = 1'b1;
        @(negedge clk_i);
        while (!inst_ack_o) @(negedge clk_i);
        @(posedge clk_i);
        #DRIVE_DLY;
        inst_req_i = 1'b0;
        @(negedge clk_i);
        while (inst_ack_o) @(negedge clk_i);
    endtask

    task automatic load_reg(input int r, input logic [31:0] value);
        send_inst(i_type(OP_LUI, 0, r, value[31:16]));
        send_inst(i_type(OP_ORI, r, r, value[15:0]));
    endtask

    // ready mostly low under back-pressure so the queue fills
    always @(posedge clk_i) begin
        #DRIVE_DLY;
        wb_ready_i = bp_mode ? ($urandom_range(0, 3) == 0) : 1'b1;
    end

    // four-phase rules seen from the instruction side
    always @(negedge clk_i) begin
        if (!reset_i) begin
            assert (!(inst_ack_o && !prev_ack) || (prev_req && inst_req_i)) else begin
                $display("four-phase broken: acknowledge rose without a held request");
                proto_errs++;
            end
            assert (!(!inst_ack_o && prev_ack) || (!prev_req && !inst_req_i)) else begin
                $display("four-phase broken: acknowledge fell while the request was high");
                proto_errs++;
            end
        end
        prev_req = inst_req_i;
        prev_ack = inst_ack_o;
    end

    always @(negedge clk_i) begin
        if (!reset_i && wb_valid_o && wb_ready_i) begin
            assert (exp_addr_q.size() != 0) else begin
                $display("write-back to r%0d arrived when none was expected", wb_addr_o);
                other_errs++;
            end
            if (exp_addr_q.size() != 0) begin
                pop_addr = exp_addr_q.pop_front();
                pop_data = exp_data_q.pop_front();
                pop_name = exp_name_q.pop_front();
                assert (wb_addr_o == pop_addr) else begin
                    $display("error %s addr expected %0d actual %0d",
                             pop_name, pop_addr, wb_addr_o);
                    data_errs++;
                end
                assert (wb_data_o == pop_data) else begin
                    $display("error %s data expected %h actual %h",
                             pop_name, pop_data, wb_data_o);
                    data_errs++;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > STEP_CYCLES * sent_cnt + BASE_CYCLES) begin
            $display("timeout after %0d cycles, %0d write-backs still missing",
                     cycle_cnt, exp_addr_q.size());
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h903b_0c5a));
        inst_req_i = 1'b0;
        inst_i     = '0;
        wb_ready_i = 1'b1;
        foreach (model_regs[i]) model_regs[i] = '0;
        wait (!reset_i);
        @(negedge clk_i);
        assert (!inst_ack_o && !wb_valid_o) else begin
            $display("acknowledge or write-back valid is high right after reset");
            other_errs++;
        end
        for (int r = 0; r < 32; r++) send_inst(i_type(OP_ORI, r, r, 16'h0));

        test_name = "r_type";
        load_reg(1, 32'h7fff_ffff);
        load_reg(2, 32'h8000_0000);
        load_reg(3, 32'hffff_ffff);
        load_reg(4, 32'h0000_0001);
        for (int r = 5; r < 32; r++) load_reg(r, $urandom);
        foreach (kept_fn[k]) begin
            if (k >= 6) begin  // skip the shifts
                send_inst(r_type(kept_fn[k], 1, 2, rnd_reg(), 0));
                send_inst(r_type(kept_fn[k], 2, 1, rnd_reg(), 0));
                send_inst(r_type(kept_fn[k], 3, 4, rnd_reg(), 0));
                repeat (3) send_inst(r_type(kept_fn[k], rnd_reg(), rnd_reg(), rnd_reg(), 0));
            end
        end

        test_name = "immediate";
        foreach (kept_op[k]) begin
            send_inst(i_type(kept_op[k], 2, rnd_reg(), 16'h8000));
            send_inst(i_type(kept_op[k], 3, rnd_reg(), 16'hffff));
            repeat (2) send_inst(i_type(kept_op[k], rnd_reg(), rnd_reg(), 16'($urandom) | 16'h8000));
        end

        test_name = "shift";
        load_reg(5, 32'h8000_0000 | $urandom);  // negative for sra
        load_reg(6, 32'h0000_001f);
        load_reg(7, 32'hffff_ffe0);  // amount bits zero
        for (int k = 0; k < 3; k++) begin
            send_inst(r_type(kept_fn[k], 0, 5, rnd_reg(), 0));
            send_inst(r_type(kept_fn[k], 0, 5, rnd_reg(), 31));
            send_inst(r_type(kept_fn[k], 0, 5, rnd_reg(), $urandom_range(1, 30)));
            send_inst(r_type(kept_fn[k + 3], 6, 5, rnd_reg(), 0));
            send_inst(r_type(kept_fn[k + 3], 7, 5, rnd_reg(), 0));
            send_inst(r_type(kept_fn[k + 3], rnd_reg(), 5, rnd_reg(), 0));
        end

        test_name = "discard";
        send_inst(i_type(6'b000010, 0, 0, 16'h0040));  // j
        send_inst(i_type(6'b100011, 1, 9, 16'h0004));  // lw
        send_inst(r_type(6'b001000, 31, 0, 0, 0));     // jr
        send_inst(r_type(6'b010000, 0, 0, 10, 0));     // mfhi
        send_inst(r_type(6'b011000, 1, 2, 0, 0));      // mult
        send_inst(r_type(FN_ADD, 1, 2, 11, 3));        // shamt must be zero
        send_inst(i_type(OP_ADDIU, 1, 0, 16'h1234));   // shows on the output, r0 unchanged
        send_inst(r_type(FN_ADDU, 0, 4, 13, 0));
        send_inst(r_type(FN_OR, 9, 10, 14, 0));

        test_name = "backpressure";
        bp_mode = 1'b1;
        repeat (200) send_inst(random_inst());
        while (exp_addr_q.size() != 0) @(negedge clk_i);
        bp_mode = 1'b0;
        repeat (10) @(negedge clk_i);

        $display("errors: data %0d, protocol %0d, other %0d over %0d instructions",
                 data_errs, proto_errs, other_errs, sent_cnt);
        if (data_errs + proto_errs + other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* decode_exec_core.f */
verilog/mips_isa_pkg.sv
verilog/core_pkg.sv
verilog/uop_if.sv
verilog/inst_decoder.sv
verilog/uop_queue.sv
verilog/reg_file.sv
verilog/alu_exec.sv
verilog/decode_exec_core.sv
dv/tb_clock_gen.sv
dv/decode_exec_core_tb.sv

/* Bender.yml */
package:
  name: decode_exec_core

sources:
  - verilog/mips_isa_pkg.sv
  - verilog/core_pkg.sv
  - verilog/uop_if.sv
  - verilog/inst_decoder.sv
  - verilog/uop_queue.sv
  - verilog/reg_file.sv
  - verilog/alu_exec.sv
  - verilog/decode_exec_core.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/decode_exec_core_tb.sv
